//--- filelist.f
+incdir+rtl
rtl/prefetch_pkg.sv
rtl/prefetch_controller.sv
rtl/axil_read_adapter.sv
rtl/fetch_fifo.sv
rtl/prefetch_unit.sv
tests/axil_inst_mem.sv
tests/tb_prefetch_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the prefetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_prefetch_unit

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_prefetch_unit -f filelist.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

//--- tests/tb_prefetch_unit.sv
// Prefetch unit testbench: clock, reset, branch and stream stimulus, watchdog, checking assertions
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_settings.svh"

module tb_prefetch_unit;

  import prefetch_pkg::*;

  localparam int          DEPTH       = `PF_FIFO_DEPTH;
  localparam int          CLK_PERIOD  = 4;
  localparam int          NUM_SEQ     = 10;
  // Generous bound per sequence, stalls and drains included
  localparam int          SEQ_CYCLES  = 1000;
  localparam int          WATCHDOG_NS = NUM_SEQ * SEQ_CYCLES * CLK_PERIOD;
  localparam logic [31:0] DATA_XOR    = 32'hA5A5_0000;
  localparam logic [31:0] ERR_LO      = 32'h0000_2040;
  localparam logic [31:0] ERR_HI      = 32'h0000_2060;

  logic        clk;
  logic        rst_n;
  logic        req_i;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        busy_o;
  logic        instr_valid_o;
  fetch_item_t instr_o;
  logic        instr_ready_i;
  logic        arvalid_o;
  axil_ar_t    ar_o;
  logic        arready_i;
  logic        rvalid_i;
  axil_r_t     r_i;
  logic        rready_o;

  integer      seed;
  // Reference model state
  logic [31:0] exp_addr;
  int          consumed;
  int          outstanding;
  logic        hs;

  prefetch_unit #(.DEPTH(DEPTH)) dut (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .branch_i(branch_i),
    .branch_addr_i(branch_addr_i), .busy_o(busy_o), .instr_valid_o(instr_valid_o),
    .instr_o(instr_o), .instr_ready_i(instr_ready_i), .arvalid_o(arvalid_o), .ar_o(ar_o),
    .arready_i(arready_i), .rvalid_i(rvalid_i), .r_i(r_i), .rready_o(rready_o)
  );

  axil_inst_mem #(
    .DATA_XOR(DATA_XOR), .ERR_LO(ERR_LO), .ERR_HI(ERR_HI), .SEED(70)
  ) u_mem (
    .clk(clk), .rst_n(rst_n), .arvalid_i(arvalid_o), .ar_i(ar_o), .arready_o(arready_i),
    .rvalid_o(rvalid_i), .r_o(r_i), .rready_i(rready_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    stop_on_failure();
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    stop_on_failure();
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Decode takes a word, flush cycles excluded
  assign hs = instr_valid_o && instr_ready_i && !branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_addr    <= '0;
      consumed    <= 0;
      outstanding <= 0;
    end else begin
      // Branch restarts the stream at the word-aligned target
      if (branch_i) begin
        exp_addr <= {branch_addr_i[31:2], 2'b00};
      end else if (hs) begin
        exp_addr <= exp_addr + 32'd4;
        consumed <= consumed + 1;
      end
      outstanding <= outstanding + ((arvalid_o && arready_i) ? 1 : 0)
                     - ((rvalid_i && rready_o) ? 1 : 0);
    end
  end

  ////////////////////////////////////////
  // Checks, sampled mid-cycle
  ////////////////////////////////////////

  a_addr: assert property (@(negedge clk) disable iff (!rst_n)
    hs |-> (instr_o.addr == exp_addr))
    else report_mismatch("instr_o.addr", instr_o.addr, exp_addr);

  a_instr: assert property (@(negedge clk) disable iff (!rst_n)
    hs |-> (instr_o.instr == (exp_addr ^ DATA_XOR)))
    else report_mismatch("instr_o.instr", instr_o.instr, exp_addr ^ DATA_XOR);

  a_err: assert property (@(negedge clk) disable iff (!rst_n)
    hs |-> (instr_o.err == in_err_window(exp_addr)))
    else report_mismatch("instr_o.err", 32'(instr_o.err), 32'(in_err_window(exp_addr)));

  // Stalled item stays put until decode takes it
  a_hold: assert property (@(negedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i && !branch_i) |=> (instr_valid_o && $stable(instr_o)))
    else report_failure("instr_valid_o or instr_o changed while decode stalled");

  a_outstanding: assert property (@(negedge clk) disable iff (!rst_n)
    outstanding <= DEPTH)
    else report_mismatch("AR minus R handshakes", 32'(outstanding), 32'(DEPTH));

  a_busy_idle: assert property (@(negedge clk) disable iff (!rst_n)
    (!req_i && (outstanding == 0) && !arvalid_o) |-> !busy_o)
    else report_mismatch("busy_o", 32'(busy_o), 32'd0);

  // Every read beat is marked as an instruction access
  a_arprot: assert property (@(negedge clk) disable iff (!rst_n)
    arvalid_o |-> ar_o.arprot[2])
    else report_mismatch("ar_o.arprot[2]", 32'(ar_o.arprot[2]), 32'd1);

  // R channel open from the first full cycle out of reset
  a_rready: assert property (@(negedge clk) (rst_n && $past(rst_n)) |-> rready_o)
    else report_mismatch("rready_o", 32'(rready_o), 32'd1);

  // Quiet outputs in reset and the first cycle after it
  a_rst_arvalid: assert property (@(negedge clk) (!rst_n || !$past(rst_n)) |-> !arvalid_o)
    else report_mismatch("arvalid_o", 32'(arvalid_o), 32'd0);
  a_rst_valid: assert property (@(negedge clk) (!rst_n || !$past(rst_n)) |-> !instr_valid_o)
    else report_mismatch("instr_valid_o", 32'(instr_valid_o), 32'd0);
  a_rst_busy: assert property (@(negedge clk) (!rst_n || !$past(rst_n)) |-> !busy_o)
    else report_mismatch("busy_o", 32'(busy_o), 32'd0);
  a_rst_rready: assert property (@(negedge clk) !rst_n |-> !rready_o)
    else report_mismatch("rready_o", 32'(rready_o), 32'd0);

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic branch_to(input logic [31:0] target);
    branch_i      = 1'b1;
    branch_addr_i = target;
    req_i         = 1'b1;
    @(posedge clk);
    #1;
    branch_i = 1'b0;
  endtask

  // Consume n words with random decode stalls long enough to fill the FIFO
  task automatic stream(input int n);
    int goal;
    int stall;
    int rnd;
    goal  = consumed + n;
    stall = 0;
    while (consumed < goal) begin
      rnd = $random(seed);
      if (stall != 0) begin
        stall = stall - 1;
      end else if ((rnd & 7) == 0) begin
        stall = 2 + ((rnd >> 4) & 7);
      end
      instr_ready_i = (stall == 0);
      @(posedge clk);
      #1;
    end
  endtask

  // Stop requesting and wait for every read to come back
  task automatic drain();
    req_i         = 1'b0;
    instr_ready_i = 1'b1;
    while (busy_o) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    int rnd;
    seed          = 70;
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    // Unaligned start just below the error window
    branch_to(32'h0000_2033);
    stream(24);
    for (int i = 1; i < NUM_SEQ; i++) begin
      rnd = $random(seed);
      branch_to(32'h0000_2000 + (rnd & 32'h0000_00FF));
      stream(8 + ((rnd >> 8) & 15));
      if ((i % 3) == 0) begin
        drain();
      end
    end
    drain();
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all sequences finished");
  end

endmodule

`default_nettype wire

//--- tests/axil_inst_mem.sv
// AXI4-Lite read-only instruction memory model with random latency and an error window
`timescale 1ns/1ps
`default_nettype none

module axil_inst_mem #(
  parameter logic [31:0] DATA_XOR = 32'hA5A5_0000,
  parameter logic [31:0] ERR_LO   = 32'h0000_2040,
  parameter logic [31:0] ERR_HI   = 32'h0000_2060,
  parameter int          SEED     = 70
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // AR channel
  input  wire logic                   arvalid_i,
  input  wire prefetch_pkg::axil_ar_t ar_i,
  output logic                        arready_o,
  // R channel
  output logic                        rvalid_o,
  output prefetch_pkg::axil_r_t       r_o,
  input  wire logic                   rready_i
);

  import prefetch_pkg::*;

  // Accepted read addresses, answered in order
  logic [31:0] pend_q [$];
  logic [31:0] addr;
  logic        ar_hs;
  logic        r_hs;
  integer      seed;
  int          wait_cnt;

  initial begin
    seed      = SEED;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    r_o       = '0;
    wait_cnt  = 0;
    forever begin
      @(posedge clk);
      // Handshakes and AR payload as seen at the edge
      ar_hs = arvalid_i && arready_o;
      r_hs  = rvalid_o && rready_i;
      if (ar_hs && rst_n) begin
        pend_q.push_back(ar_i.araddr);
      end
      #1;
      if (!rst_n) begin
        pend_q.delete();
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        wait_cnt  = 0;
      end else begin
        if (r_hs) begin
          rvalid_o = 1'b0;
        end
        // Ready three cycles out of four
        arready_o = (($random(seed) & 3) != 0);
        if (!rvalid_o && (pend_q.size() != 0)) begin
          if (wait_cnt != 0) begin
            wait_cnt = wait_cnt - 1;
          end else begin
            addr      = pend_q.pop_front();
            r_o.rdata = addr ^ DATA_XOR;
            r_o.rresp = ((addr >= ERR_LO) && (addr < ERR_HI)) ? SLVERR : OKAY;
            rvalid_o  = 1'b1;
            // Gap of 0 to 3 cycles before the next beat
            wait_cnt  = $random(seed) & 3;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/prefetch_unit.sv
// Prefetch unit top: controller, AXI4-Lite read adapter and fetch FIFO
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_settings.svh"

module prefetch_unit #(
  parameter int DEPTH = `PF_FIFO_DEPTH
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // Core side
  input  wire logic                      req_i,
  input  wire logic                      branch_i,
  input  wire logic [`PF_ADDR_W-1:0]     branch_addr_i,
  output logic                           busy_o,
  // Decode side
  output logic                           instr_valid_o,
  output prefetch_pkg::fetch_item_t      instr_o,
  input  wire logic                      instr_ready_i,
  // AXI4-Lite read channels
  output logic                           arvalid_o,
  output prefetch_pkg::axil_ar_t         ar_o,
  input  wire logic                      arready_i,
  input  wire logic                      rvalid_i,
  input  wire prefetch_pkg::axil_r_t     r_i,
  output logic                           rready_o
);

  import prefetch_pkg::*;

  // Controller to adapter
  logic        trans_valid;
  fetch_req_t  trans;
  logic        trans_ready;
  // Adapter to controller and FIFO
  logic        resp_valid;
  fetch_resp_t resp;
  // Controller to FIFO
  logic                    push_valid;
  logic                    flush;
  logic [`PF_ADDR_W-1:0]   flush_addr;
  logic [$clog2(DEPTH):0]  fifo_cnt;

  prefetch_controller #(
    .DEPTH (DEPTH)
  ) u_controller (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_o        (busy_o),
    .trans_valid_o (trans_valid),
    .trans_o       (trans),
    .trans_ready_i (trans_ready),
    .resp_valid_i  (resp_valid),
    .push_valid_o  (push_valid),
    .flush_o       (flush),
    .flush_addr_o  (flush_addr),
    .fifo_cnt_i    (fifo_cnt)
  );

  axil_read_adapter u_adapter (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_i       (trans),
    .trans_ready_o (trans_ready),
    .arvalid_o     (arvalid_o),
    .ar_o          (ar_o),
    .arready_i     (arready_i),
    .rvalid_i      (rvalid_i),
    .r_i           (r_i),
    .rready_o      (rready_o),
    .resp_valid_o  (resp_valid),
    .resp_o        (resp)
  );

  fetch_fifo #(
    .DEPTH (DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (push_valid),
    .resp_i       (resp),
    .flush_i      (flush),
    .flush_addr_i (flush_addr),
    .cnt_o        (fifo_cnt),
    .valid_o      (instr_valid_o),
    .item_o       (instr_o),
    .ready_i      (instr_ready_i)
  );

endmodule

`default_nettype wire

//--- rtl/fetch_fifo.sv
// Fetch FIFO: circular buffer of address-tagged words with flush and decode valid/ready
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_settings.svh"

module fetch_fifo #(
  parameter int DEPTH = `PF_FIFO_DEPTH
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // Write side, no back-pressure
  input  wire logic                      push_i,
  input  wire prefetch_pkg::fetch_resp_t resp_i,
  // Branch flush
  input  wire logic                      flush_i,
  input  wire logic [`PF_ADDR_W-1:0]     flush_addr_i,
  output logic [$clog2(DEPTH):0]         cnt_o,
  // Decode side
  output logic                           valid_o,
  output prefetch_pkg::fetch_item_t      item_o,
  input  wire logic                      ready_i
);

  import prefetch_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int ADDR_W = `PF_ADDR_W;

  fetch_item_t mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W:0]    cnt_q;
  // Address of the next word to arrive
  logic [ADDR_W-1:0] tag_q;
  logic              pop;
  logic              full;

  assign full    = (cnt_q == (PTR_W + 1)'(DEPTH));
  assign valid_o = (cnt_q != '0);
  assign pop     = valid_o && ready_i;
  assign item_o  = mem[rd_ptr_q];
  assign cnt_o   = cnt_q;

  ////////////////////////////////////////
  // Pointers, count and tag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      tag_q    <= '0;
    end else if (flush_i) begin
      // Drop everything, restart tagging at the branch target
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      tag_q    <= flush_addr_i;
    end else begin
      // Power of two depth, pointers wrap on their own
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
        tag_q    <= tag_q + ADDR_W'(4);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({push_i, pop})
        2'b10:   cnt_q <= cnt_q + (PTR_W + 1)'(1);
        2'b01:   cnt_q <= cnt_q - (PTR_W + 1)'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Words arrive in fetch order, so the running tag is their address
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr_q].addr  <= tag_q;
      mem[wr_ptr_q].instr <= resp_i.instr;
      mem[wr_ptr_q].err   <= resp_i.err;
    end
  end

  // Controller counting must leave room for every pushed word
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full);

endmodule

`default_nettype wire

//--- rtl/axil_read_adapter.sv
// AXI4-Lite read adapter: registered AR slot, always-ready R channel, response error mapping
`timescale 1ns/1ps
`default_nettype none

module axil_read_adapter (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // Request from controller
  input  wire logic                    trans_valid_i,
  input  wire prefetch_pkg::fetch_req_t trans_i,
  output logic                         trans_ready_o,
  // AXI4-Lite AR channel
  output logic                         arvalid_o,
  output prefetch_pkg::axil_ar_t       ar_o,
  input  wire logic                    arready_i,
  // AXI4-Lite R channel
  input  wire logic                    rvalid_i,
  input  wire prefetch_pkg::axil_r_t   r_i,
  output logic                         rready_o,
  // Response to controller and FIFO
  output logic                         resp_valid_o,
  output prefetch_pkg::fetch_resp_t    resp_o
);

  import prefetch_pkg::*;

  // Unprivileged, secure, instruction access
  localparam logic [2:0] ARPROT_INSTR = 3'b100;

  logic     arvalid_q;
  axil_ar_t ar_q;
  logic     rready_q;
  logic     accept;

  ////////////////////////////////////////
  // AR channel
  ////////////////////////////////////////

  // Slot frees up in the cycle the held beat completes
  assign trans_ready_o = !arvalid_q || arready_i;
  assign accept        = trans_valid_i && trans_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arvalid_q <= 1'b0;
    end else if (accept) begin
      arvalid_q <= 1'b1;
    end else if (arready_i) begin
      arvalid_q <= 1'b0;
    end
  end

  // Beat payload, loaded only on accept so it holds while stalled
  always_ff @(posedge clk) begin
    if (accept) begin
      ar_q.araddr <= trans_i.addr;
      ar_q.arprot <= ARPROT_INSTR;
    end
  end

  assign arvalid_o = arvalid_q;
  assign ar_o      = ar_q;

  ////////////////////////////////////////
  // R channel
  ////////////////////////////////////////

  // Low in reset, then always ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rready_q <= 1'b0;
    end else begin
      rready_q <= 1'b1;
    end
  end

  assign rready_o     = rready_q;
  assign resp_valid_o = rvalid_i && rready_q;
  assign resp_o.instr = r_i.rdata;
  // SLVERR and DECERR travel with the word
  assign resp_o.err   = !((r_i.rresp == OKAY) || (r_i.rresp == EXOKAY));

  // AR beat held until the memory takes it
  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (arvalid_o && !arready_i) |=> (arvalid_o && $stable(ar_o)));

endmodule

`default_nettype wire

//--- rtl/prefetch_controller.sv
// Prefetch controller: branch FSM, fetch address generation, outstanding and flush counters
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_settings.svh"

module prefetch_controller #(
  parameter int DEPTH = `PF_FIFO_DEPTH
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  // Core side
  input  wire logic                       req_i,
  input  wire logic                       branch_i,
  input  wire logic [`PF_ADDR_W-1:0]      branch_addr_i,
  output logic                            busy_o,
  // Request to adapter
  output logic                            trans_valid_o,
  output prefetch_pkg::fetch_req_t        trans_o,
  input  wire logic                       trans_ready_i,
  // Response from adapter, never stalled
  input  wire logic                       resp_valid_i,
  // FIFO control
  output logic                            push_valid_o,
  output logic                            flush_o,
  output logic [`PF_ADDR_W-1:0]           flush_addr_o,
  input  wire logic [$clog2(DEPTH):0]     fifo_cnt_i
);

  import prefetch_pkg::*;

  localparam int CNT_W = $clog2(DEPTH) + 1;
  localparam int ADDR_W = `PF_ADDR_W;
  // Depth widened to compare against the occupancy sum
  localparam logic [CNT_W:0] DEPTH_C = (CNT_W + 1)'(DEPTH);

  prefetch_state_e state_q;
  prefetch_state_e state_d;

  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] addr_incr;
  logic [ADDR_W-1:0] aligned_target;

  // Requests accepted by the adapter and not yet answered
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  // Answers still due for requests issued before the last branch
  logic [CNT_W-1:0] flush_cnt_q;
  logic [CNT_W-1:0] flush_cnt_d;

  logic [CNT_W-1:0] fifo_cnt_masked;
  logic [CNT_W:0]   occupancy;
  logic             accept;

  ////////////////////////////////////////
  // Address and request generation
  ////////////////////////////////////////

  // Word fetches only
  assign aligned_target = {branch_addr_i[ADDR_W-1:2], 2'b00};
  assign addr_incr      = addr_q + ADDR_W'(4);

  // FIFO empties on a branch, so its contents do not block the target request
  assign fifo_cnt_masked = branch_i ? '0 : fifo_cnt_i;
  assign occupancy       = {1'b0, fifo_cnt_masked} + {1'b0, cnt_q};

  // Never more words in flight plus buffered than the FIFO holds
  assign trans_valid_o = req_i && (occupancy < DEPTH_C);
  assign accept        = trans_valid_o && trans_ready_i;

  // Busy while a request is pending or in flight
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  // Next state and request address
  always_comb begin
    state_d      = state_q;
    trans_o.addr = addr_q;
    case (state_q)
      PF_IDLE: begin
        // A branch has priority over sequential prefetch
        if (branch_i) begin
          trans_o.addr = aligned_target;
          if (!accept) begin
            state_d = PF_BRANCH_WAIT;
          end
        end else begin
          trans_o.addr = addr_incr;
        end
      end
      PF_BRANCH_WAIT: begin
        // Replay the held target, or take a newer branch
        trans_o.addr = branch_i ? aligned_target : addr_q;
        if (accept) begin
          state_d = PF_IDLE;
        end
      end
      default: begin
        state_d = PF_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // Response bookkeeping
  ////////////////////////////////////////

  // Up on an accepted request, down on each response
  always_comb begin
    case ({accept, resp_valid_i})
      2'b10:   cnt_d = cnt_q + CNT_W'(1);
      2'b01:   cnt_d = cnt_q - CNT_W'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  // On a branch every outstanding request becomes stale
  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_d = cnt_q;
      // Response arriving in the branch cycle is already dropped
      if (resp_valid_i && (cnt_q != '0)) begin
        flush_cnt_d = cnt_q - CNT_W'(1);
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - CNT_W'(1);
    end
  end

  // Only words of the current stream reach the FIFO
  assign push_valid_o = resp_valid_i && !branch_i && (flush_cnt_q == '0);
  assign flush_o      = branch_i;
  assign flush_addr_o = aligned_target;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= PF_IDLE;
      cnt_q       <= '0;
      flush_cnt_q <= '0;
      addr_q      <= '0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      flush_cnt_q <= flush_cnt_d;
      // Hold the target until accepted, then follow the issued address
      if (branch_i || accept) begin
        addr_q <= trans_o.addr;
      end
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Words in flight plus buffered words bounded by the FIFO depth
  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    ({1'b0, fifo_cnt_i} + {1'b0, cnt_q}) <= DEPTH_C);

  // Adapter only answers requests it accepted
  a_cnt_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (cnt_q != '0));

endmodule

`default_nettype wire

//--- rtl/prefetch_pkg.sv
// Prefetch unit types: controller states, AXI response codes, request, bus and fetch structs
`default_nettype none

`include "prefetch_settings.svh"

package prefetch_pkg;

  ////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////

  // Controller states
  typedef enum logic {
    PF_IDLE        = 1'b0,
    PF_BRANCH_WAIT = 1'b1
  } prefetch_state_e;

  // AXI read response code
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Word-aligned fetch request, controller to adapter
  typedef struct packed {
    logic [`PF_ADDR_W-1:0] addr;
  } fetch_req_t;

  // AXI4-Lite read address beat
  typedef struct packed {
    logic [`PF_ADDR_W-1:0] araddr;
    logic [2:0]            arprot;
  } axil_ar_t;

  // AXI4-Lite read data beat
  typedef struct packed {
    logic [`PF_ADDR_W-1:0] rdata;
    axil_resp_e            rresp;
  } axil_r_t;

  // Returned word, adapter to FIFO
  typedef struct packed {
    logic [`PF_ADDR_W-1:0] instr;
    logic                  err;
  } fetch_resp_t;

  // FIFO entry with its fetch address
  typedef struct packed {
    logic [`PF_ADDR_W-1:0] addr;
    logic [`PF_ADDR_W-1:0] instr;
    logic                  err;
  } fetch_item_t;

endpackage

`default_nettype wire

//--- rtl/prefetch_settings.svh
// Default FIFO depth and address/data width for the instruction prefetch unit
`ifndef PREFETCH_SETTINGS_SVH
`define PREFETCH_SETTINGS_SVH

////////////////////////////////////////
// Prefetch buffer sizing
////////////////////////////////////////

// Entries in the fetch FIFO
// Also the limit on outstanding read requests
`define PF_FIFO_DEPTH 4

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

// Address and instruction word width
`define PF_ADDR_W 32

`endif
